// ==== or_tree_cfg.svh ====
/*
 * or tree page allocator configuration
 * widths of block index, summary grid, request id and occupancy tree
 */
`ifndef OR_TREE_CFG_SVH
`define OR_TREE_CFG_SVH

// 64 blocks of 4 KiB each
`define OT_INDEX_WIDTH 6

// summary grid is 8 x 8, row and column taken from the block index
`define AT_INDEX_WIDTH 3

`define REQ_ID_WIDTH 4

// 1 + 2 + 4 + 8 nodes per block
`define OT_BIT_WIDTH 15

`endif

// ==== or_tree_pkg.sv ====
/*
 * or tree package
 * request and response types plus the tree helpers shared by the
 * alloc and free datapaths
 */
`default_nettype none
`include "or_tree_cfg.svh"

package or_tree_pkg;

    typedef logic [`OT_INDEX_WIDTH-1:0] tree_idx_t;
    typedef logic [`OT_INDEX_WIDTH+2:0] page_idx_t;
    typedef logic [2:0]                 page_ofs_t;
    typedef logic [`REQ_ID_WIDTH-1:0]   req_id_t;
    typedef logic [`OT_BIT_WIDTH-1:0]   node_vec_t;
    typedef logic [`AT_INDEX_WIDTH-1:0] grid_idx_t;
    // 4k level in the msb
    typedef logic [3:0]                 level_bits_t;

    typedef enum logic [1:0] {
        size_4k,
        size_2k,
        size_1k,
        size_512
    } req_size_e;

    typedef enum logic [1:0] {
        reason_none,
        reason_no_space,
        reason_not_allocated
    } fail_reason_e;

    typedef struct packed {
        req_id_t   id;
        tree_idx_t block;
        req_size_e size;
    } alloc_req_t;

    typedef struct packed {
        req_id_t   id;
        page_idx_t page;
        req_size_e size;
    } free_req_t;

    typedef struct packed {
        req_id_t      id;
        page_idx_t    page;
        logic         fail;
        fail_reason_e reason;
    } alloc_rsp_t;

    typedef struct packed {
        req_id_t      id;
        logic         fail;
        fail_reason_e reason;
    } free_rsp_t;

    typedef struct packed {
        grid_idx_t   row;
        grid_idx_t   col;
        level_bits_t levels;
    } at_update_t;

    // leaves covered by a node, in tree bit order (bit 7 is offset 0)
    function automatic logic [7:0] leaf_mask(req_size_e size, page_ofs_t offset);
        logic [7:0] top;
        top = ~(8'hff >> (4'd8 >> size));
        return top >> offset;
    endfunction

    function automatic logic is_aligned(req_size_e size, page_ofs_t offset);
        logic [2:0] low;
        low = 3'((4'd8 >> size) - 4'd1);
        return (offset & low) == 3'd0;
    endfunction

    // rebuild the internal nodes, each one the OR of its two children
    function automatic node_vec_t fill_tree(logic [7:0] leaves);
        node_vec_t t;
        t = '0;
        t[7:0] = leaves;
        for (int i = 6; i >= 0; i--) begin
            t[14-i] = t[13-2*i] | t[12-2*i];
        end
        return t;
    endfunction

endpackage

`default_nettype wire

// ==== tree_ram.sv ====
/*
 * occupancy tree memory
 * one tree per block, two registered read ports and one write port
 */
`timescale 1ns/1ns
`default_nettype none
`include "or_tree_cfg.svh"

module tree_ram (
    input  logic                   clk,
    input  or_tree_pkg::tree_idx_t rd_block_a,
    output or_tree_pkg::node_vec_t rd_data_a,
    input  or_tree_pkg::tree_idx_t rd_block_b,
    output or_tree_pkg::node_vec_t rd_data_b,
    input  logic                   wr_en,
    input  or_tree_pkg::tree_idx_t wr_block,
    input  or_tree_pkg::node_vec_t wr_data
);

    localparam int depth = 1 << `OT_INDEX_WIDTH;

    or_tree_pkg::node_vec_t mem [depth];

    // reads return the old contents on a same-address write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_block] <= wr_data;
        end
        rd_data_a <= mem[rd_block_a];
        rd_data_b <= mem[rd_block_b];
    end

endmodule

`default_nettype wire

// ==== alloc_pick.sv ====
/*
 * alloc node picker
 * finds the lowest-addressed free node of the requested size and
 * returns its first page offset along with the updated tree
 */
`timescale 1ns/1ns
`default_nettype none

module alloc_pick (
    input  or_tree_pkg::req_size_e size,
    input  or_tree_pkg::node_vec_t node_vec,
    output or_tree_pkg::page_ofs_t offset,
    output logic                   fail,
    output or_tree_pkg::node_vec_t new_vec
);

    // bit position of the node that starts at an aligned offset
    // level base is 15 - 2^level, nodes count down from there
    function automatic logic [3:0] node_idx(or_tree_pkg::req_size_e sz,
                                            or_tree_pkg::page_ofs_t ofs);
        logic [3:0] n;
        logic [2:0] k;
        n = 4'd1 << sz;
        k = ofs >> (2'd3 - sz);
        return 4'd15 - n - 4'(k);
    endfunction

    or_tree_pkg::page_ofs_t pick_ofs;
    logic                   pick_none;

    // scan from the top so the lowest free offset is kept last
    always_comb begin
        pick_ofs  = '0;
        pick_none = 1'b1;
        for (int o = 7; o >= 0; o--) begin
            if (or_tree_pkg::is_aligned(size, 3'(o)) &&
                !node_vec[node_idx(size, 3'(o))]) begin
                pick_ofs  = 3'(o);
                pick_none = 1'b0;
            end
        end
    end

    assign offset = pick_ofs;
    assign fail   = pick_none;

    // mark the leaves under the node, the node and its ancestors follow
    always_comb begin
        if (pick_none) begin
            new_vec = node_vec;
        end else begin
            new_vec = or_tree_pkg::fill_tree(node_vec[7:0] |
                                             or_tree_pkg::leaf_mask(size, pick_ofs));
        end
    end

endmodule

`default_nettype wire

// ==== free_check.sv ====
/*
 * free request checker
 * a free is legal when the offset is aligned to the size and every
 * leaf under the node is in use; the leaves are then cleared
 */
`timescale 1ns/1ns
`default_nettype none

module free_check (
    input  or_tree_pkg::req_size_e size,
    input  or_tree_pkg::page_ofs_t offset,
    input  or_tree_pkg::node_vec_t node_vec,
    output logic                   fail,
    output or_tree_pkg::node_vec_t new_vec
);

    logic [7:0] mask;
    logic       aligned;
    logic       all_used;

    assign mask    = or_tree_pkg::leaf_mask(size, offset);
    assign aligned = or_tree_pkg::is_aligned(size, offset);

    // a partly used node cannot be freed as a whole
    assign all_used = (node_vec[7:0] & mask) == mask;

    assign fail = !aligned || !all_used;

    always_comb begin
        if (fail) begin
            new_vec = node_vec;
        end else begin
            new_vec = or_tree_pkg::fill_tree(node_vec[7:0] & ~mask);
        end
    end

endmodule

`default_nettype wire

// ==== or_tree.sv ====
/*
 * or tree page allocator top
 * three-cycle alloc and free pipeline over the occupancy memory,
 * with registered responses and a per-block level-full summary
 */
`timescale 1ns/1ns
`default_nettype none
`include "or_tree_cfg.svh"

module or_tree (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    alloc_valid,
    input  or_tree_pkg::alloc_req_t alloc_req,
    input  logic                    free_valid,
    input  or_tree_pkg::free_req_t  free_req,
    output logic                    alloc_rsp_valid,
    output or_tree_pkg::alloc_rsp_t alloc_rsp,
    output logic                    free_rsp_valid,
    output or_tree_pkg::free_rsp_t  free_rsp,
    output logic                    at_update_valid,
    output or_tree_pkg::at_update_t at_update
);

    function automatic or_tree_pkg::tree_idx_t page_block(or_tree_pkg::page_idx_t page);
        return page[`OT_INDEX_WIDTH+2:3];
    endfunction

    // one flag per level, set when no node of that level is free
    function automatic or_tree_pkg::level_bits_t level_full(or_tree_pkg::node_vec_t v);
        return {v[14], &v[13:12], &v[11:8], &v[7:0]};
    endfunction

    or_tree_pkg::tree_idx_t  clr_block;
    or_tree_pkg::node_vec_t  rd_data_a;
    or_tree_pkg::node_vec_t  rd_data_b;
    logic                    wr_en;
    or_tree_pkg::tree_idx_t  wr_block;
    or_tree_pkg::node_vec_t  wr_data;

    logic                    s1_alloc_valid;
    or_tree_pkg::alloc_req_t s1_alloc;
    logic                    s1_free_valid;
    or_tree_pkg::free_req_t  s1_free;

    or_tree_pkg::page_ofs_t  pick_ofs;
    logic                    pick_fail;
    or_tree_pkg::node_vec_t  pick_vec;
    logic                    chk_fail;
    or_tree_pkg::node_vec_t  chk_vec;

    logic                    s2_alloc_valid;
    or_tree_pkg::alloc_req_t s2_alloc;
    or_tree_pkg::page_ofs_t  s2_alloc_ofs;
    logic                    s2_alloc_fail;
    or_tree_pkg::node_vec_t  s2_alloc_vec;
    logic                    s2_free_valid;
    or_tree_pkg::free_req_t  s2_free;
    logic                    s2_free_fail;
    or_tree_pkg::node_vec_t  s2_free_vec;

    logic                    alloc_ok;
    logic                    free_ok;
    or_tree_pkg::alloc_rsp_t alloc_rsp_d;
    or_tree_pkg::free_rsp_t  free_rsp_d;
    or_tree_pkg::at_update_t at_update_d;
    or_tree_pkg::tree_idx_t  upd_block;

    // sweeps every block while reset is held, wrapping from any start value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clr_block <= clr_block + 1'b1;
        end else begin
            clr_block <= '0;
        end
    end

    tree_ram u_ram (
        .clk        (clk),
        .rd_block_a (alloc_req.block),
        .rd_data_a  (rd_data_a),
        .rd_block_b (page_block(free_req.page)),
        .rd_data_b  (rd_data_b),
        .wr_en      (wr_en),
        .wr_block   (wr_block),
        .wr_data    (wr_data)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_alloc_valid <= 1'b0;
            s1_free_valid  <= 1'b0;
            s2_alloc_valid <= 1'b0;
            s2_free_valid  <= 1'b0;
        end else begin
            s1_alloc_valid <= alloc_valid;
            s1_free_valid  <= free_valid;
            s2_alloc_valid <= s1_alloc_valid;
            s2_free_valid  <= s1_free_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_alloc     <= alloc_req;
        s1_free      <= free_req;
        s2_alloc     <= s1_alloc;
        s2_alloc_ofs <= pick_ofs;
        s2_alloc_fail <= pick_fail;
        s2_alloc_vec <= pick_vec;
        s2_free      <= s1_free;
        s2_free_fail <= chk_fail;
        s2_free_vec  <= chk_vec;
    end

    alloc_pick u_pick (
        .size     (s1_alloc.size),
        .node_vec (rd_data_a),
        .offset   (pick_ofs),
        .fail     (pick_fail),
        .new_vec  (pick_vec)
    );

    free_check u_check (
        .size     (s1_free.size),
        .offset   (s1_free.page[2:0]),
        .node_vec (rd_data_b),
        .fail     (chk_fail),
        .new_vec  (chk_vec)
    );

    assign alloc_ok = s2_alloc_valid && !s2_alloc_fail;
    assign free_ok  = s2_free_valid && !s2_free_fail;

    // reset clear takes the port, otherwise the one successful stage-2 request
    always_comb begin
        wr_en    = !rst_n || alloc_ok || free_ok;
        wr_block = alloc_ok ? s2_alloc.block : page_block(s2_free.page);
        wr_data  = alloc_ok ? s2_alloc_vec : s2_free_vec;
        if (!rst_n) begin
            wr_block = clr_block;
            wr_data  = '0;
        end
    end

    always_comb begin
        alloc_rsp_d = '0;
        if (s2_alloc_valid) begin
            alloc_rsp_d.id = s2_alloc.id;
            if (s2_alloc_fail) begin
                alloc_rsp_d.fail   = 1'b1;
                alloc_rsp_d.reason = or_tree_pkg::reason_no_space;
            end else begin
                alloc_rsp_d.page = {s2_alloc.block, s2_alloc_ofs};
            end
        end
    end

    always_comb begin
        free_rsp_d = '0;
        if (s2_free_valid) begin
            free_rsp_d.id = s2_free.id;
            if (s2_free_fail) begin
                free_rsp_d.fail   = 1'b1;
                free_rsp_d.reason = or_tree_pkg::reason_not_allocated;
            end
        end
    end

    // failed allocs still report, their vector is the unchanged tree
    assign upd_block = s2_alloc_valid ? s2_alloc.block : page_block(s2_free.page);

    always_comb begin
        at_update_d = '0;
        if (s2_alloc_valid || free_ok) begin
            at_update_d.row    = upd_block[`OT_INDEX_WIDTH-1 -: `AT_INDEX_WIDTH];
            at_update_d.col    = upd_block[`AT_INDEX_WIDTH-1:0];
            at_update_d.levels = level_full(s2_alloc_valid ? s2_alloc_vec : s2_free_vec);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alloc_rsp_valid <= 1'b0;
            alloc_rsp       <= '0;
            free_rsp_valid  <= 1'b0;
            free_rsp        <= '0;
            at_update_valid <= 1'b0;
            at_update       <= '0;
        end else begin
            alloc_rsp_valid <= s2_alloc_valid;
            alloc_rsp       <= alloc_rsp_d;
            free_rsp_valid  <= s2_free_valid;
            free_rsp        <= free_rsp_d;
            at_update_valid <= s2_alloc_valid || free_ok;
            at_update       <= at_update_d;
        end
    end

endmodule

`default_nettype wire

// ==== or_tree_asserts.sv ====
/*
 * or tree protocol checks
 * request exclusivity, fixed response latency and quiet outputs in reset
 */
`timescale 1ns/1ns
`default_nettype none

module or_tree_asserts (
    input logic clk,
    input logic rst_n,
    input logic alloc_valid,
    input logic free_valid,
    input logic alloc_rsp_valid,
    input logic free_rsp_valid,
    input logic at_update_valid
);

    // only one request kind per cycle
    assert property (@(posedge clk) disable iff (!rst_n) !(alloc_valid && free_valid))
        else $error("alloc_valid and free_valid high in the same cycle");

    // responses come exactly three cycles after the request
    assert property (@(posedge clk) disable iff (!rst_n)
                     alloc_rsp_valid == $past(alloc_valid, 3))
        else $error("alloc_rsp_valid not three cycles after alloc_valid");

    assert property (@(posedge clk) disable iff (!rst_n)
                     free_rsp_valid == $past(free_valid, 3))
        else $error("free_rsp_valid not three cycles after free_valid");

    // an update always belongs to a request three cycles back
    assert property (@(posedge clk) disable iff (!rst_n)
                     at_update_valid |-> ($past(alloc_valid, 3) || $past(free_valid, 3)))
        else $error("at_update_valid without a request three cycles earlier");

    assert property (@(posedge clk)
                     !rst_n |-> !(alloc_rsp_valid || free_rsp_valid || at_update_valid))
        else $error("response strobe high during reset");

endmodule

`default_nettype wire

// ==== tb_or_tree.sv ====
/*
 * or tree page allocator testbench
 * directed alloc and free cases plus random traffic, every response
 * compared with a page-level model of all blocks
 */
`timescale 1ns/1ns
`default_nettype none
`include "or_tree_cfg.svh"

module tb_or_tree;

    localparam int num_blocks   = 1 << `OT_INDEX_WIDTH;
    localparam int grid_cols    = 1 << `AT_INDEX_WIDTH;
    localparam int max_cycles   = 4000;
    localparam int drain_limit  = 20;
    localparam int random_reqs  = 400;

    // model outcome of one request
    typedef struct packed {
        logic                   fail;
        or_tree_pkg::page_ofs_t ofs;
        logic [7:0]             leaves;
    } ref_result_t;

    logic                    clk;
    logic                    rst_n;
    logic                    alloc_valid;
    or_tree_pkg::alloc_req_t alloc_req;
    logic                    free_valid;
    or_tree_pkg::free_req_t  free_req;
    logic                    alloc_rsp_valid;
    or_tree_pkg::alloc_rsp_t alloc_rsp;
    logic                    free_rsp_valid;
    or_tree_pkg::free_rsp_t  free_rsp;
    logic                    at_update_valid;
    or_tree_pkg::at_update_t at_update;

    // bit i set when page offset i of the block is in use
    logic [7:0]              model [num_blocks];
    int                      last_issue [num_blocks];
    or_tree_pkg::alloc_rsp_t exp_alloc [$];
    or_tree_pkg::free_rsp_t  exp_free [$];
    or_tree_pkg::at_update_t exp_update [$];
    or_tree_pkg::alloc_rsp_t ea;
    or_tree_pkg::free_rsp_t  ef;
    or_tree_pkg::at_update_t eu;
    or_tree_pkg::req_id_t    next_id;
    int                      cycle_count;
    int                      slot;
    int                      errors;
    int                      checks;
    integer                  seed;

    or_tree u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .alloc_valid     (alloc_valid),
        .alloc_req       (alloc_req),
        .free_valid      (free_valid),
        .free_req        (free_req),
        .alloc_rsp_valid (alloc_rsp_valid),
        .alloc_rsp       (alloc_rsp),
        .free_rsp_valid  (free_rsp_valid),
        .free_rsp        (free_rsp),
        .at_update_valid (at_update_valid),
        .at_update       (at_update)
    );

    bind or_tree or_tree_asserts u_asserts (
        .clk             (clk),
        .rst_n           (rst_n),
        .alloc_valid     (alloc_valid),
        .free_valid      (free_valid),
        .alloc_rsp_valid (alloc_rsp_valid),
        .free_rsp_valid  (free_rsp_valid),
        .at_update_valid (at_update_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // pages of the node that starts at first and covers span pages
    function automatic logic [7:0] node_pages(int span, int first);
        return 8'(((1 << span) - 1) << first);
    endfunction

    // alloc takes the lowest free aligned node, free needs an aligned fully used node
    function automatic ref_result_t ref_apply(logic is_alloc, or_tree_pkg::req_size_e size,
                                              or_tree_pkg::page_ofs_t ofs, logic [7:0] leaves);
        ref_result_t r;
        int          span;
        logic [7:0]  m;
        span     = 8 >> int'(size);
        r.fail   = 1'b1;
        r.ofs    = '0;
        r.leaves = leaves;
        if (is_alloc) begin
            for (int f = 8 - span; f >= 0; f -= span) begin
                m = node_pages(span, f);
                if ((leaves & m) == 8'h00) begin
                    r.fail   = 1'b0;
                    r.ofs    = 3'(f);
                    r.leaves = leaves | m;
                end
            end
        end else begin
            m = node_pages(span, int'(ofs));
            if ((int'(ofs) % span) == 0 && (leaves & m) == m) begin
                r.fail   = 1'b0;
                r.leaves = leaves & ~m;
            end
        end
        return r;
    endfunction

    // 4k level first, a level is full when each of its nodes holds a used page
    function automatic or_tree_pkg::level_bits_t ref_levels(logic [7:0] leaves);
        or_tree_pkg::level_bits_t lv;
        int                       span;
        for (int l = 0; l < 4; l++) begin
            span      = 8 >> l;
            lv[3 - l] = 1'b1;
            for (int f = 0; f < 8; f += span) begin
                if ((leaves & node_pages(span, f)) == 8'h00)
                    lv[3 - l] = 1'b0;
            end
        end
        return lv;
    endfunction

    task automatic predict(logic is_alloc, or_tree_pkg::tree_idx_t block,
                           or_tree_pkg::req_size_e size, or_tree_pkg::page_ofs_t ofs);
        ref_result_t             r;
        or_tree_pkg::alloc_rsp_t a;
        or_tree_pkg::free_rsp_t  f;
        or_tree_pkg::at_update_t u;
        r             = ref_apply(is_alloc, size, ofs, model[block]);
        model[block]  = r.leaves;
        u.row         = or_tree_pkg::grid_idx_t'(block / grid_cols);
        u.col         = or_tree_pkg::grid_idx_t'(block % grid_cols);
        u.levels      = ref_levels(r.leaves);
        a             = '0;
        f             = '0;
        a.id          = next_id;
        f.id          = next_id;
        a.fail        = r.fail;
        f.fail        = r.fail;
        if (is_alloc && r.fail)
            a.reason = or_tree_pkg::reason_no_space;
        else if (is_alloc)
            a.page = or_tree_pkg::page_idx_t'(block) * 8 + or_tree_pkg::page_idx_t'(r.ofs);
        if (!is_alloc && r.fail)
            f.reason = or_tree_pkg::reason_not_allocated;
        if (is_alloc)
            exp_alloc.push_back(a);
        else
            exp_free.push_back(f);
        if (is_alloc || !r.fail)
            exp_update.push_back(u);
        last_issue[block] = slot;
        next_id++;
    endtask

    task automatic issue_alloc(or_tree_pkg::tree_idx_t block, or_tree_pkg::req_size_e size);
        @(posedge clk);
        alloc_valid <= 1'b1;
        alloc_req   <= '{id: next_id, block: block, size: size};
        free_valid  <= 1'b0;
        predict(1'b1, block, size, '0);
        slot++;
    endtask

    task automatic issue_free(or_tree_pkg::page_idx_t page, or_tree_pkg::req_size_e size);
        @(posedge clk);
        free_valid  <= 1'b1;
        free_req    <= '{id: next_id, page: page, size: size};
        alloc_valid <= 1'b0;
        predict(1'b0, or_tree_pkg::tree_idx_t'(page / 8), size,
                or_tree_pkg::page_ofs_t'(page % 8));
        slot++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        alloc_valid <= 1'b0;
        free_valid  <= 1'b0;
        slot++;
    endtask

    task automatic report_error(string what);
        errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic report_mismatch(string name, int got, int exp);
        errors++;
        $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    // waits for every outstanding response, bounded by drain_limit cycles
    task automatic drain();
        int waited;
        waited = 0;
        idle_cycle();
        while ((exp_alloc.size() + exp_free.size() + exp_update.size()) != 0 &&
               waited < drain_limit) begin
            idle_cycle();
            waited++;
        end
        if (waited >= drain_limit)
            report_error("expected responses did not arrive");
    endtask

    task automatic finish_test(string name, int errs_before);
        if (errors == errs_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errs_before);
    endtask

    function automatic or_tree_pkg::page_idx_t page_of(int block, int ofs);
        return or_tree_pkg::page_idx_t'(block * 8 + ofs);
    endfunction

    // outputs change on the rising edge, so they are compared on the falling one
    always @(negedge clk) begin
        if (alloc_rsp_valid && exp_alloc.size() == 0) begin
            report_error("alloc response with no alloc outstanding");
        end else if (alloc_rsp_valid) begin
            ea = exp_alloc.pop_front();
            checks++;
            if (alloc_rsp.id != ea.id)
                report_mismatch("alloc_rsp.id", alloc_rsp.id, ea.id);
            if (alloc_rsp.fail != ea.fail)
                report_mismatch("alloc_rsp.fail", alloc_rsp.fail, ea.fail);
            if (alloc_rsp.reason != ea.reason)
                report_mismatch("alloc_rsp.reason", alloc_rsp.reason, ea.reason);
            if (!ea.fail && alloc_rsp.page != ea.page)
                report_mismatch("alloc_rsp.page", alloc_rsp.page, ea.page);
        end
        if (free_rsp_valid && exp_free.size() == 0) begin
            report_error("free response with no free outstanding");
        end else if (free_rsp_valid) begin
            ef = exp_free.pop_front();
            checks++;
            if (free_rsp.id != ef.id)
                report_mismatch("free_rsp.id", free_rsp.id, ef.id);
            if (free_rsp.fail != ef.fail)
                report_mismatch("free_rsp.fail", free_rsp.fail, ef.fail);
            if (free_rsp.reason != ef.reason)
                report_mismatch("free_rsp.reason", free_rsp.reason, ef.reason);
        end
        if (at_update_valid && exp_update.size() == 0) begin
            report_error("summary update with none expected");
        end else if (at_update_valid) begin
            eu = exp_update.pop_front();
            checks++;
            if (at_update.row != eu.row)
                report_mismatch("at_update.row", at_update.row, eu.row);
            if (at_update.col != eu.col)
                report_mismatch("at_update.col", at_update.col, eu.col);
            if (at_update.levels != eu.levels)
                report_mismatch("at_update.levels", at_update.levels, eu.levels);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("ERROR: run did not finish within %0d cycles", max_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int                     errs;
        int                     issued;
        logic [31:0]            r;
        or_tree_pkg::tree_idx_t blk;
        rst_n       = 1'b0;
        alloc_valid = 1'b0;
        alloc_req   = '0;
        free_valid  = 1'b0;
        free_req    = '0;
        next_id     = '0;
        cycle_count = 0;
        slot        = 0;
        errors      = 0;
        checks      = 0;
        seed        = 32'hd338_8ad0;
        for (int b = 0; b < num_blocks; b++) begin
            model[b]      = 8'h00;
            last_issue[b] = -100;
        end
        // two reset cycles plus one cycle per block for the memory clear
        repeat (2 + num_blocks) @(posedge clk);
        rst_n <= 1'b1;

        errs = errors;
        for (int i = 0; i < 9; i++) begin
            issue_alloc(6'd5, or_tree_pkg::size_512);
            drain();
        end
        finish_test("test 1 page allocs fill a block", errs);

        errs = errors;
        issue_alloc(6'd20, or_tree_pkg::size_1k);
        drain();
        issue_alloc(6'd20, or_tree_pkg::size_2k);
        drain();
        issue_alloc(6'd20, or_tree_pkg::size_4k);
        drain();
        finish_test("test 2 mixed alloc sizes", errs);

        errs = errors;
        issue_alloc(6'd33, or_tree_pkg::size_2k);
        drain();
        issue_free(page_of(33, 0), or_tree_pkg::size_2k);
        drain();
        issue_free(page_of(33, 0), or_tree_pkg::size_2k);
        drain();
        // pages 1 and 2 are both in use, only the alignment rule rejects this free
        issue_alloc(6'd33, or_tree_pkg::size_2k);
        drain();
        issue_free(page_of(33, 1), or_tree_pkg::size_1k);
        drain();
        finish_test("test 3 free rules", errs);

        // block 50 sits at row 6, column 2 of the summary grid
        errs = errors;
        issue_alloc(6'd50, or_tree_pkg::size_512);
        drain();
        issue_alloc(6'd50, or_tree_pkg::size_512);
        drain();
        issue_alloc(6'd50, or_tree_pkg::size_4k);
        drain();
        issue_free(page_of(50, 1), or_tree_pkg::size_512);
        drain();
        issue_free(page_of(50, 1), or_tree_pkg::size_512);
        drain();
        issue_free(page_of(50, 0), or_tree_pkg::size_4k);
        drain();
        finish_test("test 4 summary updates", errs);

        // eight blocks spread over rows and columns, same block kept 3 slots apart
        errs   = errors;
        issued = 0;
        while (issued < random_reqs) begin
            r   = $random(seed);
            blk = 6'(r[2:0]) * 6'd9;
            if (slot - last_issue[blk] < 3) begin
                idle_cycle();
            end else if (r[8]) begin
                issue_alloc(blk, or_tree_pkg::req_size_e'(r[4:3]));
                issued++;
            end else begin
                issue_free(page_of(int'(blk), int'(r[7:5])), or_tree_pkg::req_size_e'(r[4:3]));
                issued++;
            end
        end
        drain();
        finish_test("test 5 random traffic", errs);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
or_tree_pkg.sv
tree_ram.sv
alloc_pick.sv
free_check.sv
or_tree.sv
or_tree_asserts.sv
tb_or_tree.sv

// ==== run.sh ====
#!/bin/sh
# build and run the or tree testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_or_tree \
    -f flist.f -o sim_or_tree

./obj_dir/sim_or_tree > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1
